// File: tb/frame_dl_tests.txt
// base_addr  queue_full_percent (hex)  pixel_key
// one frame per line, run back to back
00000 00 0000
00001 14 a5a5
001f3 32 1234
12345 0a ffff
0fff0 46 0f0f
1ff00 1e 8001

// File: src.f
hdl/frame_dl_pkg.sv
hdl/burst_cache_if.sv
hdl/burst_reader.sv
hdl/burst_cache.sv
hdl/frame_sequencer.sv
hdl/frame_downloader.sv
tb/psram_model.sv
tb/frame_downloader_tb.sv

// File: Bender.yml
package:
  name: frame_downloader

sources:
  - hdl/frame_dl_pkg.sv
  - hdl/burst_cache_if.sv
  - hdl/burst_reader.sv
  - hdl/burst_cache.sv
  - hdl/frame_sequencer.sv
  - hdl/frame_downloader.sv
  - target: test
    files:
      - tb/psram_model.sv
      - tb/frame_downloader_tb.sv

// File: tb/frame_downloader_tb.sv
`timescale 1ns/1ps

module frame_downloader_tb;
    localparam int MEMORY_BURST     = 16;
    localparam int FRAME_WIDTH      = 12;
    localparam int FRAME_HEIGHT     = 3;
    localparam int ORIG_FRAME_WIDTH = 20;
    localparam int PIXELS           = MEMORY_BURST / 2;
    localparam int MAX_TESTS        = 8;
    localparam int TIMEOUT          = 5000;

    logic                      clk;
    logic                      reset_n;
    logic                      start_i;
    frame_dl_pkg::addr_t       base_addr_i;
    logic                      download_done_o;
    logic                      read_rq_o;
    frame_dl_pkg::addr_t       read_addr_o;
    logic                      read_ack_i;
    logic                      mem_rd_en_o;
    frame_dl_pkg::mem_word_t   read_data_i;
    logic                      rd_data_valid_i;
    frame_dl_pkg::queue_word_t queue_data_o;
    logic                      queue_wr_en_o;
    logic                      queue_full_i;

    logic [31:0]               tests [MAX_TESTS*3];
    logic [15:0]               key;
    int unsigned               full_pct;
    logic                      started;
    logic                      running;
    int                        done_cnt;
    int                        err_value;
    int                        err_other;
    logic                      prev_ack;
    logic                      prev_rq;
    logic                      prev_full;
    logic                      prev_done;

    frame_dl_pkg::queue_word_t exp_words [$];
    frame_dl_pkg::queue_word_t got_words [$];
    frame_dl_pkg::addr_t       exp_addr [$];

    frame_downloader #(
        .MEMORY_BURST     (MEMORY_BURST),
        .FRAME_WIDTH      (FRAME_WIDTH),
        .FRAME_HEIGHT     (FRAME_HEIGHT),
        .ORIG_FRAME_WIDTH (ORIG_FRAME_WIDTH)
    ) u_dut (.*);

    psram_model #(.MEMORY_BURST(MEMORY_BURST)) u_psram (
        .clk             (clk),
        .reset_n         (reset_n),
        .key_i           (key),
        .read_rq_i       (read_rq_o),
        .read_addr_i     (read_addr_o),
        .read_ack_o      (read_ack_i),
        .read_data_o     (read_data_i),
        .rd_data_valid_o (rd_data_valid_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // crop and pitch walk, burst by burst
    task automatic build_expected(input frame_dl_pkg::addr_t base);
        frame_dl_pkg::addr_t a;
        int n;
        exp_words.delete();
        exp_addr.delete();
        a = base;
        exp_words.push_back(frame_dl_pkg::QUEUE_FRAME_START);
        for (int r = 0; r < FRAME_HEIGHT; r++) begin
            exp_words.push_back(frame_dl_pkg::QUEUE_ROW_START);
            for (int c = 0; c < FRAME_WIDTH; c += n) begin
                n = (FRAME_WIDTH - c < PIXELS) ? FRAME_WIDTH - c : PIXELS;
                exp_addr.push_back(a);
                for (int p = 0; p < n; p++) begin
                    exp_words.push_back({1'b0, a[15:0] ^ key});
                    a = a + 1'b1;
                end
            end
            a = a + frame_dl_pkg::addr_t'(ORIG_FRAME_WIDTH - FRAME_WIDTH);
        end
        exp_words.push_back(frame_dl_pkg::QUEUE_FRAME_END);
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", err_value, err_other);
        if (err_value == 0 && err_other == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    always @(negedge clk) begin
        queue_full_i = running && (($urandom % 100) < full_pct);
    end

    // sampled values here belong to the cycle that just ended
    always @(posedge clk) begin
        if (reset_n) begin
            if (!started && (read_rq_o || mem_rd_en_o || queue_wr_en_o || download_done_o)) begin
                err_other++;
                $display("a control output went high before the first start");
            end
            if (mem_rd_en_o !== prev_ack) begin
                err_value++;
                $display("error mem_rd_en_o: got %h expected %h", mem_rd_en_o, prev_ack);
            end
            if (read_rq_o && !prev_rq) begin
                if (exp_addr.size() == 0) begin
                    err_other++;
                    $display("memory request seen when no burst was expected");
                end else if (read_addr_o !== exp_addr[0]) begin
                    err_value++;
                    $display("error read_addr_o: got %h expected %h", read_addr_o, exp_addr[0]);
                    void'(exp_addr.pop_front());
                end else begin
                    void'(exp_addr.pop_front());
                end
            end
            if (queue_wr_en_o) begin
                if (prev_full) begin
                    err_other++;
                    $display("queue write issued in the cycle after queue full");
                end
                got_words.push_back(queue_data_o);
            end
            if (download_done_o) begin
                done_cnt++;
                if (prev_done) begin
                    err_other++;
                    $display("download done stayed high for more than one cycle");
                end
                if (got_words.size() == 0 || got_words[$] !== frame_dl_pkg::QUEUE_FRAME_END) begin
                    err_other++;
                    $display("download done came before the frame end marker");
                end
            end
        end
        prev_ack  = read_ack_i;
        prev_rq   = read_rq_o;
        prev_full = queue_full_i;
        prev_done = download_done_o;
    end

    initial begin
        int cnt;
        int t;
        void'($urandom(32'h7669));
        reset_n     = 1'b0;
        start_i     = 1'b0;
        base_addr_i = '0;
        queue_full_i = 1'b0;
        key = '0;
        full_pct = 0;
        started = 1'b0;
        running = 1'b0;
        done_cnt = 0;
        err_value = 0;
        err_other = 0;
        prev_ack = 1'b0;
        prev_rq = 1'b0;
        prev_full = 1'b0;
        prev_done = 1'b0;
        foreach (tests[i]) tests[i] = '1;   // entries past the last line stay all ones
        $readmemh("tb/frame_dl_tests.txt", tests);

        repeat (3) @(posedge clk);
        @(negedge clk) reset_n = 1'b1;
        repeat (10) @(negedge clk);   // idle window before the first start

        t = 0;
        while (t < MAX_TESTS && tests[3*t] !== '1) begin
            key      = tests[3*t+2][15:0];
            full_pct = tests[3*t+1];
            build_expected(frame_dl_pkg::addr_t'(tests[3*t]));
            got_words.delete();
            done_cnt = 0;
            running  = 1'b1;
            start_i     = 1'b1;
            base_addr_i = frame_dl_pkg::addr_t'(tests[3*t]);
            started     = 1'b1;
            @(negedge clk) start_i = 1'b0;

            cnt = 0;
            while (done_cnt == 0 && cnt < TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (done_cnt == 0) begin
                err_other++;
                $display("timed out waiting for download done in test %0d", t);
                break;
            end
            running = 1'b0;
            repeat (6) @(negedge clk);

            if (done_cnt != 1) begin
                err_other++;
                $display("test %0d saw %0d done pulses instead of one", t, done_cnt);
            end
            if (exp_addr.size() != 0) begin
                err_other++;
                $display("test %0d ended with %0d bursts never requested", t, exp_addr.size());
            end
            if (got_words.size() != exp_words.size()) begin
                err_other++;
                $display("test %0d wrote %0d queue words, %0d expected",
                         t, got_words.size(), exp_words.size());
            end
            foreach (exp_words[i]) begin
                if (i < got_words.size() && got_words[i] !== exp_words[i]) begin
                    err_value++;
                    $display("error queue_data_o word %0d: got %h expected %h",
                             i, got_words[i], exp_words[i]);
                end
            end
            t++;
        end
        if (tests[0] === '1) begin
            err_other++;
            $display("no tests were read from the tests file");
        end
        finish_run();
    end

endmodule

// File: tb/psram_model.sv
`timescale 1ns/1ps

module psram_model #(
    parameter int MEMORY_BURST = 32
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [15:0]             key_i,
    input  logic                    read_rq_i,
    input  frame_dl_pkg::addr_t     read_addr_i,
    output logic                    read_ack_o,
    output frame_dl_pkg::mem_word_t read_data_o,
    output logic                    rd_data_valid_o
);
    localparam int WORDS = MEMORY_BURST / 4;

    int unsigned         delay;
    frame_dl_pkg::addr_t a;

    initial begin
        read_ack_o      = 1'b0;
        read_data_o     = '0;
        rd_data_valid_o = 1'b0;
    end

    // pixel at address a is the low half of a xor key
    always begin
        @(negedge clk);
        if (reset_n && read_rq_i) begin
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            read_ack_o = 1'b1;
            @(negedge clk);
            read_ack_o = 1'b0;
            for (int i = 0; i < WORDS; i++) begin
                delay = $urandom % 3;   // gaps between valid words
                repeat (delay) @(negedge clk);
                a = read_addr_i + frame_dl_pkg::addr_t'(2 * i);
                read_data_o     = {(a[15:0] + 16'd1) ^ key_i, a[15:0] ^ key_i};
                rd_data_valid_o = 1'b1;
                @(negedge clk);
                rd_data_valid_o = 1'b0;
            end
            while (read_rq_i) @(negedge clk);
        end
    end

endmodule

// File: hdl/frame_downloader.sv
`timescale 1ns/1ps

module frame_downloader #(
    parameter int MEMORY_BURST     = 32,
    parameter int FRAME_WIDTH      = 480,
    parameter int FRAME_HEIGHT     = 272,
    parameter int ORIG_FRAME_WIDTH = 640
) (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic                      start_i,
    input  frame_dl_pkg::addr_t       base_addr_i,
    output logic                      download_done_o,

    output logic                      read_rq_o,
    output frame_dl_pkg::addr_t       read_addr_o,
    input  logic                      read_ack_i,
    output logic                      mem_rd_en_o,
    input  frame_dl_pkg::mem_word_t   read_data_i,
    input  logic                      rd_data_valid_i,

    output frame_dl_pkg::queue_word_t queue_data_o,
    output logic                      queue_wr_en_o,
    input  logic                      queue_full_i
);
    logic                burst_req;
    frame_dl_pkg::addr_t burst_addr;
    logic                burst_filled;

    burst_cache_if #(.MEMORY_BURST(MEMORY_BURST)) cache_bus ();

    burst_reader #(
        .MEMORY_BURST (MEMORY_BURST)
    ) u_burst_reader (
        .clk             (clk),
        .reset_n         (reset_n),
        .burst_req_i     (burst_req),
        .burst_addr_i    (burst_addr),
        .burst_filled_o  (burst_filled),
        .read_rq_o       (read_rq_o),
        .read_addr_o     (read_addr_o),
        .read_ack_i      (read_ack_i),
        .mem_rd_en_o     (mem_rd_en_o),
        .read_data_i     (read_data_i),
        .rd_data_valid_i (rd_data_valid_i),
        .cache_wr        (cache_bus.writer)
    );

    burst_cache #(
        .MEMORY_BURST (MEMORY_BURST)
    ) u_burst_cache (
        .clk     (clk),
        .reset_n (reset_n),
        .cache   (cache_bus.store)
    );

    frame_sequencer #(
        .MEMORY_BURST     (MEMORY_BURST),
        .FRAME_WIDTH      (FRAME_WIDTH),
        .FRAME_HEIGHT     (FRAME_HEIGHT),
        .ORIG_FRAME_WIDTH (ORIG_FRAME_WIDTH)
    ) u_frame_sequencer (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .base_addr_i     (base_addr_i),
        .download_done_o (download_done_o),
        .queue_data_o    (queue_data_o),
        .queue_wr_en_o   (queue_wr_en_o),
        .queue_full_i    (queue_full_i),
        .burst_req_o     (burst_req),
        .burst_addr_o    (burst_addr),
        .burst_filled_i  (burst_filled),
        .cache_rd        (cache_bus.reader)
    );

endmodule

// File: hdl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int MEMORY_BURST     = 32,
    parameter int FRAME_WIDTH      = 480,
    parameter int FRAME_HEIGHT     = 272,
    parameter int ORIG_FRAME_WIDTH = 640
) (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic                      start_i,
    input  frame_dl_pkg::addr_t       base_addr_i,
    output logic                      download_done_o,

    output frame_dl_pkg::queue_word_t queue_data_o,
    output logic                      queue_wr_en_o,
    input  logic                      queue_full_i,

    output logic                      burst_req_o,
    output frame_dl_pkg::addr_t       burst_addr_o,
    input  logic                      burst_filled_i,

    burst_cache_if.reader             cache_rd
);
    localparam int PIXELS    = MEMORY_BURST / 2;
    localparam int PIX_IDX_W = frame_dl_pkg::idx_width(PIXELS);
    localparam int COL_W     = frame_dl_pkg::idx_width(FRAME_WIDTH);
    localparam int ROW_W     = frame_dl_pkg::idx_width(FRAME_HEIGHT);

    localparam frame_dl_pkg::addr_t ROW_SKIP =
        frame_dl_pkg::addr_t'(ORIG_FRAME_WIDTH - FRAME_WIDTH);

    typedef enum logic [3:0] {
        S_IDLE,
        S_FRAME_START,
        S_ROW_START,
        S_BURST_REQ,
        S_BURST_WAIT,
        S_PIX_READ,
        S_PIX_WRITE,
        S_FRAME_END,
        S_DONE
    } state_t;

    state_t                    state;
    frame_dl_pkg::addr_t       addr_q;
    frame_dl_pkg::addr_t       burst_step;
    frame_dl_pkg::addr_t       addr_step;
    logic [COL_W-1:0]          col_cnt;
    logic [ROW_W-1:0]          row_cnt;
    logic [PIX_IDX_W-1:0]      pix_idx;
    logic                      row_last;
    logic                      burst_last;
    logic                      frame_last;
    logic                      queue_issue;
    frame_dl_pkg::queue_word_t marker;

    assign row_last   = col_cnt == COL_W'(FRAME_WIDTH - 1);
    assign burst_last = pix_idx == PIX_IDX_W'(PIXELS - 1);
    assign frame_last = row_cnt == ROW_W'(FRAME_HEIGHT - 1);

    // pixels pushed from this burst, plus the pitch gap at row end
    assign burst_step = frame_dl_pkg::addr_t'(pix_idx) + frame_dl_pkg::addr_t'(1);
    assign addr_step  = row_last ? burst_step + ROW_SKIP : burst_step;

    // a write goes out only if full was low in the cycle before
    assign queue_issue = !queue_full_i &&
                         (state == S_FRAME_START || state == S_ROW_START ||
                          state == S_PIX_WRITE   || state == S_FRAME_END);

    always_comb begin
        case (state)
            S_FRAME_START: marker = frame_dl_pkg::QUEUE_FRAME_START;
            S_ROW_START:   marker = frame_dl_pkg::QUEUE_ROW_START;
            default:       marker = frame_dl_pkg::QUEUE_FRAME_END;
        endcase
    end

    assign burst_req_o  = state == S_BURST_REQ;
    assign burst_addr_o = addr_q;

    assign cache_rd.rd_en  = state == S_PIX_READ;
    assign cache_rd.rd_idx = pix_idx;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= S_IDLE;
            addr_q          <= '0;
            col_cnt         <= '0;
            row_cnt         <= '0;
            pix_idx         <= '0;
            queue_wr_en_o   <= 1'b0;
            download_done_o <= 1'b0;
        end else begin
            queue_wr_en_o   <= queue_issue;
            download_done_o <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        addr_q  <= base_addr_i;
                        row_cnt <= '0;
                        state   <= S_FRAME_START;
                    end
                end
                S_FRAME_START: if (queue_issue) state <= S_ROW_START;
                S_ROW_START: begin
                    if (queue_issue) begin
                        col_cnt <= '0;
                        state   <= S_BURST_REQ;
                    end
                end
                S_BURST_REQ: begin
                    pix_idx <= '0;
                    state   <= S_BURST_WAIT;
                end
                S_BURST_WAIT: if (burst_filled_i) state <= S_PIX_READ;
                S_PIX_READ:   state <= S_PIX_WRITE;   // cache output valid next cycle
                S_PIX_WRITE: begin
                    if (queue_issue) begin
                        if (row_last || burst_last)
                            addr_q <= addr_q + addr_step;

                        if (row_last) begin
                            row_cnt <= row_cnt + 1'b1;
                            state   <= frame_last ? S_FRAME_END : S_ROW_START;
                        end else if (burst_last) begin
                            col_cnt <= col_cnt + 1'b1;
                            state   <= S_BURST_REQ;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            pix_idx <= pix_idx + 1'b1;
                            state   <= S_PIX_READ;
                        end
                    end
                end
                S_FRAME_END: if (queue_issue) state <= S_DONE;
                S_DONE: begin
                    download_done_o <= 1'b1;   // one cycle behind the end marker
                    state           <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (queue_issue)
            queue_data_o <= (state == S_PIX_WRITE) ? {1'b0, cache_rd.rd_pixel} : marker;
    end

    a_no_write_after_full: assert property (
        @(posedge clk) disable iff (!reset_n)
        queue_wr_en_o |-> !$past(queue_full_i)
    );

endmodule

// File: hdl/burst_cache.sv
`timescale 1ns/1ps

module burst_cache #(
    parameter int MEMORY_BURST = 32
) (
    input  logic         clk,
    input  logic         reset_n,
    burst_cache_if.store cache
);
    localparam int WORDS      = MEMORY_BURST / 4;
    localparam int PIXELS     = MEMORY_BURST / 2;
    localparam int WORD_IDX_W = frame_dl_pkg::idx_width(WORDS);

    frame_dl_pkg::mem_word_t mem [WORDS];
    frame_dl_pkg::mem_word_t rd_word;
    logic [WORD_IDX_W-1:0]   rd_word_idx;

    assign rd_word_idx = WORD_IDX_W'(cache.rd_idx >> 1);
    assign rd_word     = mem[rd_word_idx];

    always_ff @(posedge clk) begin
        if (cache.wr_en)
            mem[cache.wr_idx] <= cache.wr_word;

        // even pixel sits in the low half
        if (cache.rd_en)
            cache.rd_pixel <= cache.rd_idx[0] ? rd_word[31:16] : rd_word[15:0];
    end

    a_rd_idx_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        cache.rd_en |-> int'(cache.rd_idx) < PIXELS
    );

endmodule

// File: hdl/burst_reader.sv
`timescale 1ns/1ps

module burst_reader #(
    parameter int MEMORY_BURST = 32
) (
    input  logic                    clk,
    input  logic                    reset_n,

    input  logic                    burst_req_i,
    input  frame_dl_pkg::addr_t     burst_addr_i,
    output logic                    burst_filled_o,

    output logic                    read_rq_o,
    output frame_dl_pkg::addr_t     read_addr_o,
    input  logic                    read_ack_i,
    output logic                    mem_rd_en_o,
    input  frame_dl_pkg::mem_word_t read_data_i,
    input  logic                    rd_data_valid_i,

    burst_cache_if.writer           cache_wr
);
    localparam int WORDS      = MEMORY_BURST / 4;
    localparam int WORD_IDX_W = frame_dl_pkg::idx_width(WORDS);

    logic [WORD_IDX_W-1:0] word_cnt;
    logic                  acked;      // read enable already given for this burst
    logic                  last_word;

    assign last_word = word_cnt == WORD_IDX_W'(WORDS - 1);

    // words go straight into consecutive cache slots
    assign cache_wr.wr_en   = rd_data_valid_i & read_rq_o;
    assign cache_wr.wr_idx  = word_cnt;
    assign cache_wr.wr_word = read_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_rq_o      <= 1'b0;
            mem_rd_en_o    <= 1'b0;
            burst_filled_o <= 1'b0;
            acked          <= 1'b0;
            word_cnt       <= '0;
        end else begin
            mem_rd_en_o    <= 1'b0;
            burst_filled_o <= 1'b0;

            if (!read_rq_o) begin
                if (burst_req_i) begin
                    read_rq_o <= 1'b1;
                    acked     <= 1'b0;
                    word_cnt  <= '0;
                end
            end else begin
                if (read_ack_i && !acked) begin
                    acked       <= 1'b1;
                    mem_rd_en_o <= 1'b1;   // single pulse, cycle after ack
                end

                if (rd_data_valid_i) begin
                    if (last_word) begin
                        read_rq_o      <= 1'b0;
                        burst_filled_o <= 1'b1;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // address held stable for the whole request
    always_ff @(posedge clk) begin
        if (burst_req_i && !read_rq_o)
            read_addr_o <= burst_addr_i;
    end

    // memory may only stream words for a request it has acknowledged
    a_valid_in_burst: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd_data_valid_i |-> read_rq_o && acked
    );

endmodule

// File: hdl/burst_cache_if.sv
`timescale 1ns/1ps

interface burst_cache_if #(
    parameter int MEMORY_BURST = 32
);
    localparam int WORD_IDX_W = frame_dl_pkg::idx_width(MEMORY_BURST / 4);
    localparam int PIX_IDX_W  = frame_dl_pkg::idx_width(MEMORY_BURST / 2);

    // word side, filled by the burst reader
    logic                    wr_en;
    logic [WORD_IDX_W-1:0]   wr_idx;
    frame_dl_pkg::mem_word_t wr_word;

    // pixel side, drained by the sequencer
    logic                    rd_en;
    logic [PIX_IDX_W-1:0]    rd_idx;
    frame_dl_pkg::pixel_t    rd_pixel;   // one cycle after rd_en

    modport writer (output wr_en, wr_idx, wr_word);

    modport reader (output rd_en, rd_idx, input rd_pixel);

    modport store (
        input  wr_en, wr_idx, wr_word,
        input  rd_en, rd_idx,
        output rd_pixel
    );

endinterface

// File: hdl/frame_dl_pkg.sv
package frame_dl_pkg;

    // memory side, addresses count pixels and not bytes
    typedef logic [20:0] addr_t;
    typedef logic [15:0] pixel_t;

    // two pixels per word, lower address in [15:0]
    typedef logic [31:0] mem_word_t;

    // msb set only for markers
    typedef logic [16:0] queue_word_t;

    localparam queue_word_t QUEUE_FRAME_START = 17'h10000;
    localparam queue_word_t QUEUE_ROW_START   = 17'h10001;
    localparam queue_word_t QUEUE_FRAME_END   = 17'h1ffff;

    // index width for n entries, never below one bit
    function automatic int idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage
